//--- hdl/mdioPkg.sv
// MDIO management frame definitions
// Opcode and receiver state enums, frame header struct, bit positions
package mdioPkg;

    // Clause-22 opcode field, read and write only
    typedef enum logic [1:0]
    {
        OP_INVALID = 2'b00,     // Clause-45 address, not handled
        OP_WRITE   = 2'b01,
        OP_READ    = 2'b10,
        OP_RSVD    = 2'b11      // Clause-45 read, not handled
    } mdioOpE;

    // Receiver FSM
    typedef enum logic [1:0]
    {
        RX_IDLE = 2'd0,         // Preamble search
        RX_RECV = 2'd1,         // Frame bits shifting in
        RX_SAVE = 2'd2          // One cycle to log the frame
    } rxStateE;

    // Header fields, live from the frame shift register
    typedef struct packed
    {
        logic       startOk;    // ST pattern 01 seen
        mdioOpE     op;
        logic [4:0] phyAddr;
        logic [4:0] regAddr;
    } mdioHdrS;

    localparam logic [4:0] PHY_ADDR     = 5'd1;    // Our address on the bus
    localparam int         PREAMBLE_LEN = 32;      // Consecutive ones before ST
    localparam int         FRAME_BITS   = 32;      // ST through data
    localparam int         HDR_LAST_BIT = 14;      // Header bits 0..13 received by then
    localparam int         TA_FIRST_BIT = 14;      // First turnaround bit, MSB-first index

endpackage

//--- hdl/phyRegPkg.sv
// PHY register image and debug port definitions
// Fixed register values, link dependent bits and the debug status word layout
package phyRegPkg;

    // BMSR with link bits clear, bits 5 and 2 follow the link flag
    localparam logic [15:0] BMSR_BASE  = 16'h7908;
    localparam logic [15:0] REG17_LINK = 16'hac00;   // 1G full duplex, link up
    localparam logic [4:0]  REG17_ADDR = 5'd17;      // Vendor specific status

    // Standard registers 0..15
    localparam logic [15:0] REG_INIT [16] = '{
        16'h1040,       // BMCR, 1G with auto-negotiation enabled
        BMSR_BASE,      // BMSR, link bits added in the bank
        16'h7e19,       // PHYID1
        16'hc010,       // PHYID2, model 1 rev 0
        16'h0801,       // ANAR, asymmetric pause
        16'h0c01,       // ANLPAR
        16'h0000,       // ANER
        16'h0000,       // ANNPTR
        16'h0000,       // ANNPRR
        16'h0200,       // GBCR, advertise 1G full duplex
        16'h7c00,       // GBSR, master
        16'h0000,
        16'h0000,
        16'h0000,       // MACR
        16'h0000,       // MAADR
        16'h2000        // GBESR, 1G full duplex capable
    };

    // Debug address map, low byte of regRaddr
    localparam logic [7:0] DBG_LOG_BASE    = 8'hb0;  // b0..bf frame log
    localparam logic [7:0] DBG_STATUS_ADDR = 8'haf;

    // Debug status word, MSB first
    typedef struct packed
    {
        logic [2:0] zero3;
        logic [4:0] regNew;          // Last unsupported register seen
        logic [2:0] zero2;
        logic [4:0] phyAddr;
        logic [2:0] zero1;
        logic [4:0] regAddr;
        logic [3:0] preambleErrCnt;
        logic       zero0;
        logic       startOk;
        logic [1:0] op;
    } dbgStatusS;

endpackage

//--- hdl/mdioFrameRx.sv
// MDIO frame receiver
// Samples the host MDC on the system clock, finds the preamble and shifts in
// the 32-bit frame, taking reply bits back from mdioIn on reads
module mdioFrameRx
(
    input  logic             ctrl_wen,
    input  logic             rstN,
    input  logic             mdc,
    input  logic             mdioOut,          // Host drive level
    input  logic             mdioTri,          // Host released the line
    input  logic             mdioIn,           // Our own reply, looped back
    output mdioPkg::mdioHdrS hdr,
    output logic [4:0]       bitIdx,
    output logic             mdcRise,
    output logic             frameDone,
    output logic [31:0]      frameWord,
    output logic [3:0]       preambleErrCnt
);

    logic [1:0]       mdcSync;    // [1] is the synchronized copy
    logic             mdcLast;    // For edge detection
    logic [1:0]       outSync;    // Kept in step with MDC
    logic [1:0]       triSync;
    logic [4:0]       preCnt;     // Consecutive preamble ones
    logic             doRead;
    mdioPkg::rxStateE rxState;

    // Header straight from the shift register
    assign hdr.startOk = (frameWord[31:30] == 2'b01);
    assign hdr.op      = mdioPkg::mdioOpE'(frameWord[29:28]);
    assign hdr.phyAddr = frameWord[27:23];
    assign hdr.regAddr = frameWord[22:18];

    // Reply data is taken from our own output, not the host's line
    assign doRead = (hdr.op == mdioPkg::OP_READ) &&
                    (bitIdx >= 5'(mdioPkg::TA_FIRST_BIT));

    // Synchronizers and MDC rise pulse
    always_ff @(posedge ctrl_wen or negedge rstN)
    begin
        if (!rstN)
        begin
            mdcSync <= 2'b00;
            mdcLast <= 1'b0;
            outSync <= 2'b00;
            triSync <= 2'b00;
            mdcRise <= 1'b0;
        end
        else
        begin
            mdcSync <= {mdcSync[0], mdc};
            outSync <= {outSync[0], mdioOut};
            triSync <= {triSync[0], mdioTri};
            mdcLast <= mdcSync[1];
            mdcRise <= mdcSync[1] & ~mdcLast;   // Third cycle after the MDC edge
        end
    end

    always_ff @(posedge ctrl_wen or negedge rstN)
    begin
        if (!rstN)
        begin
            rxState        <= mdioPkg::RX_IDLE;
            preCnt         <= 5'd0;
            bitIdx         <= 5'd0;
            frameWord      <= 32'd0;   // Status word reads 0 after reset
            frameDone      <= 1'b0;
            preambleErrCnt <= 4'd0;
        end
        else
        begin
            frameDone <= 1'b0;
            case (rxState)
                mdioPkg::RX_IDLE:
                begin
                    if (mdcRise)
                    begin
                        if (triSync[1])
                            preCnt <= 5'd0;                 // Released line, no error
                        else if (outSync[1])
                        begin
                            if (preCnt == 5'(mdioPkg::PREAMBLE_LEN - 1))
                            begin
                                preCnt  <= 5'd0;
                                rxState <= mdioPkg::RX_RECV;
                            end
                            else
                                preCnt <= preCnt + 5'd1;
                        end
                        else
                        begin
                            // Driven zero breaks the preamble
                            preambleErrCnt <= preambleErrCnt + 4'd1;   // Wraps
                            preCnt         <= 5'd0;
                        end
                    end
                end
                mdioPkg::RX_RECV:
                begin
                    if (mdcRise)
                    begin
                        frameWord[~bitIdx] <= doRead ? mdioIn : outSync[1];   // MSB first
                        bitIdx <= bitIdx + 5'd1;                             // Wraps to 0 at end
                        if (bitIdx == 5'(mdioPkg::FRAME_BITS - 1))
                        begin
                            rxState   <= mdioPkg::RX_SAVE;
                            frameDone <= 1'b1;
                        end
                    end
                end
                mdioPkg::RX_SAVE:
                    rxState <= mdioPkg::RX_IDLE;   // Responder logs during this cycle
                default:
                    rxState <= mdioPkg::RX_IDLE;
            endcase
        end
    end

    assert property (@(posedge ctrl_wen) disable iff (!rstN)
        frameDone |=> !frameDone);

    assert property (@(posedge ctrl_wen) disable iff (!rstN)
        rxState inside {mdioPkg::RX_IDLE, mdioPkg::RX_RECV, mdioPkg::RX_SAVE});

endmodule

//--- hdl/phyRegBank.sv
// PHY register bank
// Holds the link flag and looks up the read value for the current header
module phyRegBank
(
    input  logic             ctrl_wen,
    input  logic             rstN,
    input  logic             linkOnMask,       // One-cycle update strobe
    input  logic             linkOnBit,
    input  mdioPkg::mdioHdrS hdr,
    output logic             linkOn,
    output logic [15:0]      readData,
    output logic             regUnsupported
);

    logic [15:0] regImage [16];
    logic        ourAddr;     // Frame targets PHY_ADDR
    logic        isStd;       // Registers 0..15
    logic        isReg17;
    logic        validOp;

    always_ff @(posedge ctrl_wen or negedge rstN)
    begin
        if (!rstN)
            linkOn <= 1'b0;
        else if (linkOnMask)
            linkOn <= linkOnBit;
    end

    // Fixed image with BMSR link bits patched in
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            regImage[i] = phyRegPkg::REG_INIT[i];
        end
        // Autoneg complete on bit 5, link status on bit 2
        regImage[1] = phyRegPkg::BMSR_BASE | {10'd0, linkOn, 2'b00, linkOn, 2'b00};
    end

    assign ourAddr = (hdr.phyAddr == mdioPkg::PHY_ADDR);
    assign isStd   = ourAddr && !hdr.regAddr[4];
    assign isReg17 = ourAddr && (hdr.regAddr == phyRegPkg::REG17_ADDR);
    assign validOp = (hdr.op != mdioPkg::OP_INVALID) && (hdr.op != mdioPkg::OP_RSVD);

    always_comb
    begin
        if (isStd)
            readData = regImage[hdr.regAddr[3:0]];
        else if (isReg17 && linkOn)
            readData = phyRegPkg::REG17_LINK;
        else
            readData = 16'd0;   // Other address or unknown register
    end

    // Upper registers we do not model, kept for debug
    assign regUnsupported = ourAddr && hdr.regAddr[4] && !isReg17 && validOp;

    assert property (@(posedge ctrl_wen) disable iff (!rstN)
        !$stable(linkOn) |-> $past(linkOnMask));

endmodule

//--- hdl/mdioResponder.sv
// MDIO reply and debug logic
// Drives read data onto mdioIn, logs finished frames and decodes debug reads
module mdioResponder
(
    input  logic             ctrl_wen,
    input  logic             rstN,
    input  mdioPkg::mdioHdrS hdr,
    input  logic [4:0]       bitIdx,
    input  logic             mdcRise,
    input  logic             frameDone,
    input  logic [31:0]      frameWord,
    input  logic [3:0]       preambleErrCnt,
    input  logic [15:0]      readData,
    input  logic             regUnsupported,
    input  logic [15:0]      regRaddr,
    output logic             mdioIn,
    output logic [31:0]      regRdata
);

    logic [5:0]             nextBit;     // Frame bit shown after this MDC rise
    logic [5:0]             taIdx;       // Offset into the reply word
    logic [17:0]            replyWord;   // Two TA zeros over the data
    logic                   replyBit;
    logic [31:0]            dbgLog [16]; // Circular frame log
    logic [3:0]             logPtr;
    logic [4:0]             regNew;
    phyRegPkg::dbgStatusS   statusWord;

    assign nextBit   = {1'b0, bitIdx} + 6'd1;
    assign taIdx     = nextBit - 6'(mdioPkg::TA_FIRST_BIT);
    assign replyWord = {2'b00, readData};

    always_comb
    begin
        replyBit = 1'b0;
        if ((hdr.op == mdioPkg::OP_READ) &&
            (nextBit >= 6'(mdioPkg::TA_FIRST_BIT)) &&
            (nextBit < 6'(mdioPkg::FRAME_BITS)))
            replyBit = replyWord[5'd17 - taIdx[4:0]];   // MSB first
    end

    // One bit ahead, so it is settled well before the host samples
    always_ff @(posedge ctrl_wen or negedge rstN)
    begin
        if (!rstN)
            mdioIn <= 1'b0;
        else if (mdcRise)
            mdioIn <= replyBit;
    end

    always_ff @(posedge ctrl_wen or negedge rstN)
    begin
        if (!rstN)
        begin
            logPtr <= 4'd0;
            regNew <= 5'd0;
        end
        else if (frameDone)
        begin
            logPtr <= logPtr + 4'd1;   // Oldest entry overwritten
            if (regUnsupported)
                regNew <= hdr.regAddr;
        end
    end

    always_ff @(posedge ctrl_wen)
    begin
        if (frameDone)
            dbgLog[logPtr] <= frameWord;
    end

    always_comb
    begin
        statusWord                = '0;
        statusWord.regNew         = regNew;
        statusWord.phyAddr        = hdr.phyAddr;
        statusWord.regAddr        = hdr.regAddr;
        statusWord.preambleErrCnt = preambleErrCnt;
        statusWord.startOk        = hdr.startOk;
        statusWord.op             = hdr.op;
    end

    // Debug port decode on the low address byte
    always_comb
    begin
        if (regRaddr[7:4] == phyRegPkg::DBG_LOG_BASE[7:4])
            regRdata = dbgLog[regRaddr[3:0]];
        else if (regRaddr[7:0] == phyRegPkg::DBG_STATUS_ADDR)
            regRdata = statusWord;
        else
            regRdata = 32'd0;
    end

    assert property (@(posedge ctrl_wen) disable iff (!rstN)
        (hdr.op != mdioPkg::OP_READ) |-> !mdioIn);

endmodule

//--- hdl/virtualPhy.sv
// Virtual Ethernet PHY top
// Clause-22 MDIO slave at address 1 with a fixed register image and debug port
module virtualPhy
(
    input  logic        ctrl_wen,
    input  logic        rstN,
    input  logic        mdc,           // Host management clock, sampled
    input  logic        mdioOut,       // Host data out
    input  logic        mdioTri,       // Host tri-state enable
    input  logic        linkOnMask,
    input  logic        linkOnBit,
    input  logic [15:0] regRaddr,      // Debug read address
    output logic        mdioIn,        // Data back to the host
    output logic        linkOn,
    output logic [31:0] regRdata
);

    mdioPkg::mdioHdrS hdr;
    logic [4:0]       bitIdx;
    logic             mdcRise;
    logic             frameDone;
    logic [31:0]      frameWord;
    logic [3:0]       preambleErrCnt;
    logic [15:0]      readData;
    logic             regUnsupported;

    mdioFrameRx frameRxInst
    (
        .ctrl_wen       (ctrl_wen),
        .rstN           (rstN),
        .mdc            (mdc),
        .mdioOut        (mdioOut),
        .mdioTri        (mdioTri),
        .mdioIn         (mdioIn),
        .hdr            (hdr),
        .bitIdx         (bitIdx),
        .mdcRise        (mdcRise),
        .frameDone      (frameDone),
        .frameWord      (frameWord),
        .preambleErrCnt (preambleErrCnt)
    );

    phyRegBank regBankInst
    (
        .ctrl_wen       (ctrl_wen),
        .rstN           (rstN),
        .linkOnMask     (linkOnMask),
        .linkOnBit      (linkOnBit),
        .hdr            (hdr),
        .linkOn         (linkOn),
        .readData       (readData),
        .regUnsupported (regUnsupported)
    );

    mdioResponder responderInst
    (
        .ctrl_wen       (ctrl_wen),
        .rstN           (rstN),
        .hdr            (hdr),
        .bitIdx         (bitIdx),
        .mdcRise        (mdcRise),
        .frameDone      (frameDone),
        .frameWord      (frameWord),
        .preambleErrCnt (preambleErrCnt),
        .readData       (readData),
        .regUnsupported (regUnsupported),
        .regRaddr       (regRaddr),
        .mdioIn         (mdioIn),
        .regRdata       (regRdata)
    );

endmodule

//--- tb/phyChecker.sv
// MDIO checker for the virtual PHY
// Decodes host frames at the ports, predicts replies, log and status, counts errors
module phyChecker
(
    input  logic        ctrl_wen,
    input  logic        rstN,
    input  logic        mdc,
    input  logic        mdioOut,
    input  logic        mdioTri,
    input  logic        linkOnMask,
    input  logic        linkOnBit,
    input  logic [15:0] regRaddr,
    input  logic        dbgReq,         // Testbench marks a debug read
    input  logic [15:0] hostReply,      // Read data as the host sampled it
    input  logic        mdioIn,
    input  logic        linkOn,
    input  logic [31:0] regRdata,
    output int          errCount,
    output int          checkCount
);

    logic        mdcPrev;
    logic        linkExp;        // Link flag as the strobes set it
    logic        inFrame;
    logic        outOfReset;
    logic        hostPending;    // Read finished, host copy not yet compared
    int          preCnt;         // Consecutive driven ones
    int          bitNo;          // Frame bit, 0 is the first ST bit
    int          errTotal = 0;
    int          checkTotal = 0;
    logic [31:0] word;           // Frame as the PHY should log it
    logic [31:0] seen;           // mdioIn at each frame bit
    logic [15:0] replyExp;
    logic [3:0]  errCntExp;
    logic [4:0]  regNewExp;
    logic [31:0] lastWord;       // Header source of the status word
    logic [31:0] logExp [16];
    logic [3:0]  logPtr;

    // Expected read data from the register rules
    function automatic logic [15:0] expectReply(input logic [4:0] phy, input logic [4:0] regA,
                                                input logic link);
        if (phy != 5'd1)
            return 16'h0000;
        case (regA)
            5'd0:    return 16'h1040;
            5'd1:    return link ? 16'h792c : 16'h7908;   // Link and AN complete bits
            5'd2:    return 16'h7e19;
            5'd3:    return 16'hc010;
            5'd4:    return 16'h0801;
            5'd5:    return 16'h0c01;
            5'd9:    return 16'h0200;
            5'd10:   return 16'h7c00;
            5'd15:   return 16'h2000;
            5'd17:   return link ? 16'hac00 : 16'h0000;
            default: return 16'h0000;
        endcase
    endfunction

    function automatic logic isUnsupported(input logic [31:0] w);
        return (w[27:23] == 5'd1) && w[22] && (w[22:18] != 5'd17) &&
               ((w[29:28] == 2'b01) || (w[29:28] == 2'b10));
    endfunction

    function automatic logic [31:0] expectDebug(input logic [15:0] addr);
        logic startOk;
        startOk = (lastWord[31:30] == 2'b01);
        if (addr[7:4] == 4'hb)
            return logExp[addr[3:0]];
        if (addr[7:0] == 8'haf)
            return {3'b000, regNewExp, 3'b000, lastWord[27:23], 3'b000, lastWord[22:18],
                    errCntExp, 1'b0, startOk, lastWord[29:28]};
        return 32'h0;
    endfunction

    task automatic reportMismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        errTotal++;
    endtask

    // One MDC rise, preamble search or frame bit
    task automatic takeBit();
        logic isReadOp;
        isReadOp = (word[29:28] == 2'b10);   // Valid from bit 4 on
        if (!inFrame)
        begin
            if (mdioIn !== 1'b0)
                reportMismatch("mdioIn high outside a frame");
            if (mdioTri)
                preCnt = 0;                   // Released line, no error
            else if (mdioOut)
            begin
                preCnt++;
                if (preCnt == 32)
                begin
                    inFrame = 1'b1;
                    bitNo   = 0;
                    preCnt  = 0;
                end
            end
            else
            begin
                errCntExp = errCntExp + 4'd1;  // Broken preamble
                preCnt    = 0;
            end
        end
        else
        begin
            seen[31 - bitNo] = mdioIn;
            if (isReadOp && bitNo >= 14)
                word[31 - bitNo] = (bitNo < 16) ? 1'b0 : replyExp[31 - bitNo];
            else
                word[31 - bitNo] = mdioOut;
            if (bitNo == 13)
                replyExp = expectReply(word[27:23], word[22:18], linkExp);   // Header done
            if (bitNo == 31)
            begin
                checkTotal++;
                if (seen !== (isReadOp ? {16'h0, replyExp} : 32'h0))
                    reportMismatch($sformatf("phy %0d reg %0d op %b replied %h, expected %h",
                        word[27:23], word[22:18], word[29:28], seen[15:0],
                        isReadOp ? replyExp : 16'h0));
                logExp[logPtr] = word;
                logPtr         = logPtr + 4'd1;
                lastWord       = word;
                if (isUnsupported(word))
                    regNewExp = word[22:18];
                hostPending = isReadOp;       // Host copy lands after its last MDC rise
                inFrame     = 1'b0;
            end
            else
                bitNo++;
        end
    endtask

    always @(posedge ctrl_wen or negedge rstN)
    begin
        if (!rstN)
        begin
            mdcPrev     = 1'b0;
            linkExp     = 1'b0;
            inFrame     = 1'b0;
            outOfReset  = 1'b0;
            hostPending = 1'b0;
            preCnt      = 0;
            bitNo       = 0;
            word        = 32'h0;
            seen        = 32'h0;
            replyExp    = 16'h0;
            errCntExp   = 4'd0;
            regNewExp   = 5'd0;
            lastWord    = 32'h0;
            logPtr      = 4'd0;
        end
        else
        begin
            if (!outOfReset && mdioIn !== 1'b0)
                reportMismatch("mdioIn not 0 after reset");
            outOfReset = 1'b1;
            if (linkOn !== linkExp)
                reportMismatch($sformatf("linkOn is %b, expected %b", linkOn, linkExp));
            if (linkOnMask)
                linkExp = linkOnBit;          // DUT follows on the next cycle
            if (dbgReq)
            begin
                checkTotal++;
                if (regRdata !== expectDebug(regRaddr))
                    reportMismatch($sformatf("debug %h read %h, expected %h",
                        regRaddr, regRdata, expectDebug(regRaddr)));
            end
            if (hostPending && !mdc)
            begin
                hostPending = 1'b0;
                checkTotal++;
                if (hostReply !== replyExp)
                    reportMismatch($sformatf("host sampled %h, expected %h",
                        hostReply, replyExp));
            end
            if (mdc && !mdcPrev)
                takeBit();
            mdcPrev = mdc;
            errCount   <= errTotal;
            checkCount <= checkTotal;
        end
    end

endmodule

//--- tb/tbVirtualPhy.sv
// Virtual PHY testbench
// Host side MDIO frames, link strobes and debug reads against the PHY
module tbVirtualPhy;

    localparam int FRAME_COUNT    = 63;    // Broken preamble counted as one
    localparam int TIMEOUT_CYCLES = FRAME_COUNT * 64 * 8 + 2000;

    logic        ctrl_wen = 1'b0;
    logic        rstN;
    logic        mdc;
    logic        mdioOut;
    logic        mdioTri;
    logic        linkOnMask;
    logic        linkOnBit;
    logic [15:0] regRaddr;
    logic        dbgReq;
    logic        mdioIn;
    logic        linkOn;
    logic [31:0] regRdata;
    logic [15:0] lastReply;      // Data as the host sampled it
    int          seed = 3975;
    int          errCount;
    int          checkCount;
    int          errMark = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          cycleCount;

    always #5 ctrl_wen = ~ctrl_wen;

    virtualPhy virtualPhy_inst
    (
        .ctrl_wen   (ctrl_wen),
        .rstN       (rstN),
        .mdc        (mdc),
        .mdioOut    (mdioOut),
        .mdioTri    (mdioTri),
        .linkOnMask (linkOnMask),
        .linkOnBit  (linkOnBit),
        .regRaddr   (regRaddr),
        .mdioIn     (mdioIn),
        .linkOn     (linkOn),
        .regRdata   (regRdata)
    );

    phyChecker phyCheckerInst
    (
        .ctrl_wen   (ctrl_wen),
        .rstN       (rstN),
        .mdc        (mdc),
        .mdioOut    (mdioOut),
        .mdioTri    (mdioTri),
        .linkOnMask (linkOnMask),
        .linkOnBit  (linkOnBit),
        .regRaddr   (regRaddr),
        .dbgReq     (dbgReq),
        .hostReply  (lastReply),
        .mdioIn     (mdioIn),
        .linkOn     (linkOn),
        .regRdata   (regRdata),
        .errCount   (errCount),
        .checkCount (checkCount)
    );

    // One MDC period, 4 cycles low then 4 high
    task automatic clockBit(input logic bitVal, input logic letGo, output logic sampled);
        @(posedge ctrl_wen);
        mdc     <= 1'b0;
        mdioOut <= bitVal;
        mdioTri <= letGo;
        repeat (4) @(posedge ctrl_wen);
        sampled = mdioIn;                // Just before the rise
        mdc <= 1'b1;
        repeat (3) @(posedge ctrl_wen);
    endtask

    task automatic idleLine(input int cycles);
        @(posedge ctrl_wen);
        mdc     <= 1'b0;
        mdioOut <= 1'b1;
        mdioTri <= 1'b0;
        repeat (cycles) @(posedge ctrl_wen);   // Log entry settles in here
    endtask

    task automatic sendFrame(input logic [1:0] op, input logic [4:0] phy, input logic [4:0] regA,
                             input logic [15:0] data);
        logic [31:0] frame;
        logic        sampled;
        frame = {2'b01, op, phy, regA, 2'b10, data};
        for (int i = 0; i < 32; i++)
            clockBit(1'b1, 1'b0, sampled);
        for (int i = 0; i < 32; i++)
        begin
            clockBit(frame[31 - i], (op == 2'b10) && (i >= 14), sampled);   // Released from TA
            if (i >= 16)
                lastReply[31 - i] = sampled;
        end
        idleLine(8);
    endtask

    task automatic readReg(input logic [4:0] phy, input logic [4:0] regA);
        sendFrame(2'b10, phy, regA, 16'h0000);
    endtask

    task automatic writeReg(input logic [4:0] phy, input logic [4:0] regA, input logic [15:0] data);
        sendFrame(2'b01, phy, regA, data);
    endtask

    task automatic breakPreamble(input int ones);
        logic sampled;
        for (int i = 0; i < ones; i++)
            clockBit(1'b1, 1'b0, sampled);
        clockBit(1'b0, 1'b0, sampled);   // Driven zero
        idleLine(8);
    endtask

    task automatic strobeLink(input logic value);
        @(posedge ctrl_wen);
        linkOnMask <= 1'b1;
        linkOnBit  <= value;
        @(posedge ctrl_wen);
        linkOnMask <= 1'b0;
        repeat (2) @(posedge ctrl_wen);
    endtask

    task automatic readDebug(input logic [15:0] addr);
        @(posedge ctrl_wen);
        regRaddr <= addr;
        dbgReq   <= 1'b1;
        @(posedge ctrl_wen);
        dbgReq <= 1'b0;
    endtask

    task automatic finishTest(input int num, input string name);
        @(posedge ctrl_wen);                  // Checker counts catch up
        if (errCount == errMark)
        begin
            testsPassed++;
            $display("test %0d %s: pass", num, name);
        end
        else
        begin
            testsFailed++;
            $display("test %0d %s: fail with %0d errors", num, name, errCount - errMark);
        end
        errMark = errCount;
    endtask

    initial
    begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES)
        begin
            @(posedge ctrl_wen);
            cycleCount++;
        end
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        logic [4:0]  phy;
        logic [4:0]  regA;
        logic [15:0] data;
        rstN       = 1'b0;
        mdc        = 1'b0;
        mdioOut    = 1'b1;
        mdioTri    = 1'b0;
        linkOnMask = 1'b0;
        linkOnBit  = 1'b0;
        regRaddr   = 16'h0000;
        dbgReq     = 1'b0;
        repeat (5) @(posedge ctrl_wen);
        rstN <= 1'b1;
        repeat (2) @(posedge ctrl_wen);

        readDebug(16'h00af);
        readDebug(16'h0012);                  // Unmapped
        finishTest(1, "reset state");

        for (int r = 0; r < 16; r++)
            readReg(5'd1, 5'(r));
        strobeLink(1'b1);
        for (int r = 0; r < 16; r++)
            readReg(5'd1, 5'(r));             // BMSR now with link bits
        finishTest(2, "register image");

        readReg(5'd1, 5'd17);
        strobeLink(1'b0);
        readReg(5'd1, 5'd17);
        regA = 5'(18 + {$random(seed)} % 14);
        readReg(5'd1, regA);
        readDebug(16'h00af);                  // regNew shows regA
        finishTest(3, "register 17 and unsupported");

        for (int i = 0; i < 2; i++)
        begin
            phy = 5'($random(seed));
            if (phy == 5'd1)
                phy = 5'd2;
            readReg(phy, 5'($random(seed)));
        end
        for (int i = 0; i < 3; i++)
        begin
            regA = 5'({$random(seed)} % 16);
            data = 16'($random(seed));
            writeReg(5'd1, regA, data);
            readReg(5'd1, regA);              // Image unchanged
        end
        finishTest(4, "other address and writes");

        breakPreamble(10);
        readDebug(16'h00af);
        readReg(5'd1, 5'd3);
        readDebug(16'h00af);
        finishTest(5, "broken preamble");

        strobeLink(1'b1);
        for (int i = 0; i < 18; i++)
        begin
            phy  = ({$random(seed)} % 4 == 0) ? 5'($random(seed)) : 5'd1;
            regA = 5'($random(seed));
            data = 16'($random(seed));
            if ($random(seed) % 2 == 0)
                writeReg(phy, regA, data);
            else
                readReg(phy, regA);
        end
        for (int a = 0; a < 16; a++)
            readDebug(16'h00b0 + 16'(a));
        readDebug(16'h00af);
        finishTest(6, "frame log");

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 testsPassed, testsFailed, checkCount, errCount);
        if (testsFailed == 0 && errCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- virtualPhy.f
hdl/mdioPkg.sv
hdl/phyRegPkg.sv
hdl/mdioFrameRx.sv
hdl/phyRegBank.sv
hdl/mdioResponder.sv
hdl/virtualPhy.sv
tb/phyChecker.sv
tb/tbVirtualPhy.sv

//--- run.sh
#!/bin/sh
# Builds the virtual PHY testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert --top-module tbVirtualPhy -f virtualPhy.f \
    --Mdir obj_dir -o simVirtualPhy > build.log 2>&1 \
    && ./obj_dir/simVirtualPhy > sim.log 2>&1 \
    || echo "build or simulation did not complete, see build.log and sim.log"

cat sim.log 2>/dev/null
grep -q "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
